// File: cachePkg.sv
// Cache geometry constants for a 4-way, 128-set, 8-word-line cache
// Address field, word, line, tag entry and age types
// Age reset constant for the replacement RAM
package cachePkg;

  localparam int NumWays      = 4;
  localparam int WordsPerLine = 8;
  localparam int NumSets      = 128;

  localparam int AddrBits   = 32;
  localparam int WordBits   = 32;
  // Byte lanes inside a word, ignored by the cache
  localparam int ByteBits   = 2;
  localparam int OffsetBits = $clog2(WordsPerLine);
  localparam int IndexBits  = $clog2(NumSets);
  localparam int TagBits    = AddrBits - IndexBits - OffsetBits - ByteBits;
  localparam int WayBits    = $clog2(NumWays);
  localparam int AgeBits    = $clog2(NumWays);

  typedef logic [AddrBits-1:0]   addrT;
  typedef logic [WordBits-1:0]   wordT;
  typedef logic [TagBits-1:0]    tagT;
  typedef logic [IndexBits-1:0]  indexT;
  typedef logic [OffsetBits-1:0] offsetT;
  typedef logic [WayBits-1:0]    wayIdxT;
  typedef logic [AgeBits-1:0]    ageT;

  // Word 0 at the low end of the line
  typedef wordT [WordsPerLine-1:0] lineT;

  typedef struct packed {
    logic valid;
    tagT  tag;
  } tagEntryT;

  // One age per way, way 0 in the low bits
  typedef ageT [NumWays-1:0] setAgesT;

  // Way i starts out with age i
  localparam setAgesT initAges = {2'd3, 2'd2, 2'd1, 2'd0};

endpackage

// File: syncRam.sv
`timescale 1ns/1ps
// Generic single-port RAM with synchronous read
// Every entry and the read register reset to a given value
module syncRam #(
  parameter type PayloadT   = logic [31:0],
  parameter int  Depth      = 128,
  parameter PayloadT ResetValue = PayloadT'(0)
) (
  input  logic            clk,
  input  logic            resetn,
  input  logic            en,
  input  logic            we,
  input  cachePkg::indexT addr,
  input  PayloadT         wdata,
  output PayloadT         rdata
);

  PayloadT mem [Depth];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < Depth; i++) begin
        mem[i] <= ResetValue;
      end
      rdata <= ResetValue;
    end else if (en) begin
      // Read data holds its last value during a write
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

// File: cacheWay.sv
`timescale 1ns/1ps
// One cache way: tag entry RAM and line RAM
// Tag compare, read word select and line merge for writes
module cacheWay #(
  parameter int WayIndex = 0
) (
  input  logic              clk,
  input  logic              resetn,
  input  logic              rdEn,
  input  logic              wrOp,
  input  logic              commit,
  input  cachePkg::indexT   index,
  input  cachePkg::tagT     reqTag,
  input  cachePkg::offsetT  reqOffset,
  input  cachePkg::wordT    reqData,
  input  cachePkg::wayIdxT  commitWay,
  output logic              wayHit,
  output logic              wayValid,
  output cachePkg::wordT    wayWord
);
  import cachePkg::*;

  tagEntryT storedEntry;
  tagEntryT newEntry;
  lineT     storedLine;
  lineT     newLine;
  logic     wayWrite;
  logic     ramEn;

  assign wayValid = storedEntry.valid;
  assign wayHit   = storedEntry.valid && (storedEntry.tag == reqTag);
  assign wayWord  = storedLine[reqOffset];

  // Only writes touch the way; a read hit just ages the set
  assign wayWrite = commit && wrOp && (commitWay == wayIdxT'(WayIndex));
  assign ramEn    = rdEn || wayWrite;

  assign newEntry = '{valid: 1'b1, tag: reqTag};

  always_comb begin
    // Miss allocates a zero line holding only the new word
    newLine = wayHit ? storedLine : '0;
    newLine[reqOffset] = reqData;
  end

  syncRam #(
    .PayloadT   (tagEntryT),
    .Depth      (NumSets),
    .ResetValue ('0)
  ) u_tagRam (
    .clk    (clk),
    .resetn (resetn),
    .en     (ramEn),
    .we     (wayWrite),
    .addr   (index),
    .wdata  (newEntry),
    .rdata  (storedEntry)
  );

  syncRam #(
    .PayloadT   (lineT),
    .Depth      (NumSets),
    .ResetValue ('0)
  ) u_lineRam (
    .clk    (clk),
    .resetn (resetn),
    .en     (ramEn),
    .we     (wayWrite),
    .addr   (index),
    .wdata  (newLine),
    .rdata  (storedLine)
  );

endmodule

// File: ageReplacer.sv
`timescale 1ns/1ps
// Age-based replacement for all sets
// Per-set age RAM, victim choice and age update on commit
module ageReplacer (
  input  logic                          clk,
  input  logic                          resetn,
  input  logic                          rdEn,
  input  logic                          commit,
  input  cachePkg::indexT               index,
  input  cachePkg::wayIdxT              commitWay,
  input  logic [cachePkg::NumWays-1:0]  wayValid,
  output cachePkg::wayIdxT              victimWay
);
  import cachePkg::*;

  setAgesT curAges;
  setAgesT newAges;
  logic    ramEn;

  assign ramEn = rdEn || commit;

  // Lowest invalid way first, otherwise the oldest way (age 0)
  always_comb begin
    victimWay = '0;
    if (&wayValid) begin
      for (int w = 0; w < NumWays; w++) begin
        if (curAges[w] == '0) begin
          victimWay = wayIdxT'(w);
        end
      end
    end else begin
      for (int w = NumWays - 1; w >= 0; w--) begin
        if (!wayValid[w]) begin
          victimWay = wayIdxT'(w);
        end
      end
    end
  end

  // Used way becomes youngest, ways above its old age shift down
  always_comb begin
    ageT oldAge;
    oldAge = curAges[commitWay];
    for (int w = 0; w < NumWays; w++) begin
      if (wayIdxT'(w) == commitWay) begin
        newAges[w] = ageT'(NumWays - 1);
      end else if (curAges[w] > oldAge) begin
        newAges[w] = curAges[w] - ageT'(1);
      end else begin
        newAges[w] = curAges[w];
      end
    end
  end

  syncRam #(
    .PayloadT   (setAgesT),
    .Depth      (NumSets),
    .ResetValue (initAges)
  ) u_ageRam (
    .clk    (clk),
    .resetn (resetn),
    .en     (ramEn),
    .we     (commit),
    .addr   (index),
    .wdata  (newAges),
    .rdata  (curAges)
  );

endmodule

// File: cacheCtrl.sv
`timescale 1ns/1ps
// Request controller: address split and request registers
// Commit strobe and way choice for the lookup cycle
// Registered ready, hit and read data two cycles after the request
module cacheCtrl (
  input  logic                                   clk,
  input  logic                                   resetn,
  input  logic                                   rd,
  input  logic                                   wr,
  input  cachePkg::addrT                         addr,
  input  cachePkg::wordT                         writeData,
  input  logic [cachePkg::NumWays-1:0]           wayHit,
  input  cachePkg::wordT [cachePkg::NumWays-1:0] wayWord,
  input  cachePkg::wayIdxT                       victimWay,
  output cachePkg::indexT                        index,
  output logic                                   rdEn,
  output logic                                   wrOp,
  output logic                                   commit,
  output cachePkg::tagT                          reqTag,
  output cachePkg::offsetT                       reqOffset,
  output cachePkg::wordT                         reqData,
  output cachePkg::wayIdxT                       commitWay,
  output logic                                   ready,
  output logic                                   hit,
  output cachePkg::wordT                         readData
);
  import cachePkg::*;

  logic   request;
  logic   lookupValid;
  logic   anyHit;
  wayIdxT hitWay;

  assign request = rd || wr;

  // Request fields held until the next request
  always_ff @(posedge clk) begin
    if (request) begin
      reqTag    <= addr[AddrBits-1 -: TagBits];
      index     <= addr[ByteBits+OffsetBits +: IndexBits];
      reqOffset <= addr[ByteBits +: OffsetBits];
      reqData   <= writeData;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      rdEn        <= 1'b0;
      wrOp        <= 1'b0;
      lookupValid <= 1'b0;
    end else begin
      rdEn        <= request;
      lookupValid <= rdEn;
      if (request) begin
        wrOp <= wr;
      end
    end
  end

  // Tags are unique within a set, so at most one way hits
  always_comb begin
    hitWay = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (wayHit[w]) begin
        hitWay = wayIdxT'(w);
      end
    end
  end

  assign anyHit = |wayHit;

  // Every hit ages the set; a write miss also allocates the victim
  assign commit    = lookupValid && (anyHit || wrOp);
  assign commitWay = anyHit ? hitWay : victimWay;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      ready    <= 1'b0;
      hit      <= 1'b0;
      readData <= '0;
    end else begin
      ready    <= lookupValid;
      hit      <= lookupValid && anyHit;
      readData <= (lookupValid && anyHit && !wrOp) ? wayWord[hitWay] : '0;
    end
  end

endmodule

// File: cacheTop.sv
`timescale 1ns/1ps
// 4-way set-associative data cache top level
// Request controller, four way slices and the age replacer
module cacheTop (
  input  logic           clk,
  input  logic           resetn,
  input  logic           rd,
  input  logic           wr,
  input  cachePkg::addrT addr,
  input  cachePkg::wordT writeData,
  output logic           ready,
  output logic           hit,
  output cachePkg::wordT readData
);
  import cachePkg::*;

  indexT                 index;
  logic                  rdEn;
  logic                  wrOp;
  logic                  commit;
  tagT                   reqTag;
  offsetT                reqOffset;
  wordT                  reqData;
  wayIdxT                commitWay;
  wayIdxT                victimWay;
  logic [NumWays-1:0]    wayHit;
  logic [NumWays-1:0]    wayValid;
  wordT [NumWays-1:0]    wayWord;

  cacheCtrl u_cacheCtrl (
    .clk       (clk),
    .resetn    (resetn),
    .rd        (rd),
    .wr        (wr),
    .addr      (addr),
    .writeData (writeData),
    .wayHit    (wayHit),
    .wayWord   (wayWord),
    .victimWay (victimWay),
    .index     (index),
    .rdEn      (rdEn),
    .wrOp      (wrOp),
    .commit    (commit),
    .reqTag    (reqTag),
    .reqOffset (reqOffset),
    .reqData   (reqData),
    .commitWay (commitWay),
    .ready     (ready),
    .hit       (hit),
    .readData  (readData)
  );

  for (genvar w = 0; w < NumWays; w++) begin : genWay
    cacheWay #(
      .WayIndex (w)
    ) u_cacheWay (
      .clk       (clk),
      .resetn    (resetn),
      .rdEn      (rdEn),
      .wrOp      (wrOp),
      .commit    (commit),
      .index     (index),
      .reqTag    (reqTag),
      .reqOffset (reqOffset),
      .reqData   (reqData),
      .commitWay (commitWay),
      .wayHit    (wayHit[w]),
      .wayValid  (wayValid[w]),
      .wayWord   (wayWord[w])
    );
  end

  ageReplacer u_ageReplacer (
    .clk       (clk),
    .resetn    (resetn),
    .rdEn      (rdEn),
    .commit    (commit),
    .index     (index),
    .commitWay (commitWay),
    .wayValid  (wayValid),
    .victimWay (victimWay)
  );

endmodule

// File: cacheTop_assertions.sv
`timescale 1ns/1ps
// Concurrent assertions on request spacing and ready/hit timing
// Bound into every cacheTop instance
module cacheTopAssertions (
  input logic clk,
  input logic resetn,
  input logic rd,
  input logic wr,
  input logic ready,
  input logic hit
);

  int assertFailures = 0;

  assert property (@(posedge clk) disable iff (!resetn) !(rd && wr))
    else begin
      assertFailures++;
      $error("rd and wr high in the same cycle");
    end

  // Requests are spaced at least two cycles apart
  assert property (@(posedge clk) disable iff (!resetn) (rd || wr) |=> !(rd || wr))
    else begin
      assertFailures++;
      $error("request in the cycle after a request");
    end

  // Ready rises at the second edge after the request edge, so it is sampled one edge later
  assert property (@(posedge clk) disable iff (!resetn) (rd || wr) |-> ##3 ready)
    else begin
      assertFailures++;
      $error("ready missing two cycles after a request");
    end

  assert property (@(posedge clk) disable iff (!resetn) ready |-> $past(rd || wr, 3))
    else begin
      assertFailures++;
      $error("ready without a request two cycles earlier");
    end

  assert property (@(posedge clk) disable iff (!resetn) ready |=> !ready)
    else begin
      assertFailures++;
      $error("ready longer than one cycle");
    end

  assert property (@(posedge clk) disable iff (!resetn) hit |-> ready)
    else begin
      assertFailures++;
      $error("hit high without ready");
    end

endmodule

bind cacheTop cacheTopAssertions u_cacheTopAssertions (
  .clk    (clk),
  .resetn (resetn),
  .rd     (rd),
  .wr     (wr),
  .ready  (ready),
  .hit    (hit)
);

// File: cacheTb.sv
`timescale 1ns/1ps
// Table-driven testbench for the 4-way data cache
// Clock, reset, request table, compare tasks, timeout and summary
module cacheTb;
  import cachePkg::*;

  localparam logic [19:0] TagA = 20'h0a000;
  localparam logic [19:0] TagB = 20'h0b000;
  localparam logic [19:0] TagC = 20'h0c000;
  localparam logic [19:0] TagD = 20'h0d000;
  localparam logic [19:0] TagE = 20'h0e000;

  logic clk;
  logic resetn;
  logic rd;
  logic wr;
  addrT addr;
  wordT writeData;
  logic ready;
  logic hit;
  wordT readData;

  // Table columns: write flag, address, write data, expected hit, expected read data
  logic rowWrite[$];
  addrT rowAddr[$];
  wordT rowData[$];
  logic rowHit[$];
  wordT rowExpect[$];

  int errorCount = 0;
  int rowsPassed = 0;
  int rowsFailed = 0;
  int cycleCount = 0;
  int cycleLimit = 0;

  cacheTop u_cacheTop (
    .clk       (clk),
    .resetn    (resetn),
    .rd        (rd),
    .wr        (wr),
    .addr      (addr),
    .writeData (writeData),
    .ready     (ready),
    .hit       (hit),
    .readData  (readData)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // Tag in bits 31:12, set in 11:5, word offset in 4:2
  function automatic addrT makeAddr(input logic [19:0] tag, input logic [6:0] set,
                                    input logic [2:0] offset);
    return {tag, set, offset, 2'b00};
  endfunction

  task automatic addRow(input logic isWrite, input addrT a, input wordT d,
                        input logic expHit, input wordT expData);
    rowWrite.push_back(isWrite);
    rowAddr.push_back(a);
    rowData.push_back(d);
    rowHit.push_back(expHit);
    rowExpect.push_back(expData);
  endtask

  task automatic checkHit(input int row, input logic got, input logic expected);
    if (got !== expected) begin
      $display("** Error row %0d: hit = 0x%h, expected 0x%h", row, got, expected);
      errorCount++;
    end
  endtask

  task automatic checkWord(input int row, input wordT got, input wordT expected);
    if (got !== expected) begin
      $display("** Error row %0d: readData = 0x%h, expected 0x%h", row, got, expected);
      errorCount++;
    end
  endtask

  task automatic buildTable();
    // Read after reset misses
    addRow(1'b0, makeAddr(20'h12345, 7'd3, 3'd1), '0, 1'b0, '0);
    // Write miss allocates, then reads of the same line
    addRow(1'b1, makeAddr(20'h00aa1, 7'd10, 3'd2), 32'hdeadbeef, 1'b0, '0);
    addRow(1'b0, makeAddr(20'h00aa1, 7'd10, 3'd2), '0, 1'b1, 32'hdeadbeef);
    addRow(1'b0, makeAddr(20'h00aa1, 7'd10, 3'd5), '0, 1'b1, '0);
    // Write hit to another word of that line
    addRow(1'b1, makeAddr(20'h00aa1, 7'd10, 3'd5), 32'h0badf00d, 1'b1, '0);
    addRow(1'b0, makeAddr(20'h00aa1, 7'd10, 3'd2), '0, 1'b1, 32'hdeadbeef);
    addRow(1'b0, makeAddr(20'h00aa1, 7'd10, 3'd5), '0, 1'b1, 32'h0badf00d);
    // Fill ways 0 to 3 of set 20
    addRow(1'b1, makeAddr(TagA, 7'd20, 3'd0), 32'h000000a0, 1'b0, '0);
    addRow(1'b1, makeAddr(TagB, 7'd20, 3'd0), 32'h000000b0, 1'b0, '0);
    addRow(1'b1, makeAddr(TagC, 7'd20, 3'd0), 32'h000000c0, 1'b0, '0);
    addRow(1'b1, makeAddr(TagD, 7'd20, 3'd0), 32'h000000d0, 1'b0, '0);
    // Reading in fill order leaves A oldest again
    addRow(1'b0, makeAddr(TagA, 7'd20, 3'd0), '0, 1'b1, 32'h000000a0);
    addRow(1'b0, makeAddr(TagB, 7'd20, 3'd0), '0, 1'b1, 32'h000000b0);
    addRow(1'b0, makeAddr(TagC, 7'd20, 3'd0), '0, 1'b1, 32'h000000c0);
    addRow(1'b0, makeAddr(TagD, 7'd20, 3'd0), '0, 1'b1, 32'h000000d0);
    // A becomes youngest, so E replaces B
    addRow(1'b0, makeAddr(TagA, 7'd20, 3'd0), '0, 1'b1, 32'h000000a0);
    addRow(1'b1, makeAddr(TagE, 7'd20, 3'd0), 32'h000000e0, 1'b0, '0);
    addRow(1'b0, makeAddr(TagB, 7'd20, 3'd0), '0, 1'b0, '0);
    addRow(1'b0, makeAddr(TagA, 7'd20, 3'd0), '0, 1'b1, 32'h000000a0);
    addRow(1'b0, makeAddr(TagE, 7'd20, 3'd0), '0, 1'b1, 32'h000000e0);
    // Neighbouring sets stay apart
    addRow(1'b1, makeAddr(20'h55555, 7'd40, 3'd7), 32'h11112222, 1'b0, '0);
    addRow(1'b1, makeAddr(20'h55555, 7'd41, 3'd7), 32'h33334444, 1'b0, '0);
    addRow(1'b0, makeAddr(20'h55555, 7'd40, 3'd7), '0, 1'b1, 32'h11112222);
    addRow(1'b0, makeAddr(20'h55555, 7'd41, 3'd7), '0, 1'b1, 32'h33334444);
    addRow(1'b0, makeAddr(20'h00aa1, 7'd10, 3'd2), '0, 1'b1, 32'hdeadbeef);
  endtask

  // One request cycle, wait for ready, then one idle cycle
  task automatic runRow(input int r);
    int   waitCycles;
    int   errorsBefore;
    logic gotReady;
    errorsBefore = errorCount;
    rd = !rowWrite[r];
    wr = rowWrite[r];
    addr = rowAddr[r];
    writeData = rowData[r];
    @(negedge clk);
    rd = 1'b0;
    wr = 1'b0;
    waitCycles = 1;
    gotReady = ready;
    while (!gotReady && waitCycles < 4) begin
      @(negedge clk);
      waitCycles++;
      gotReady = ready;
    end
    if (!gotReady) begin
      $display("Row %0d: ready did not arrive within 4 cycles", r);
      errorCount++;
    end else begin
      checkHit(r, hit, rowHit[r]);
      checkWord(r, readData, rowExpect[r]);
    end
    if (errorCount == errorsBefore) begin
      rowsPassed++;
    end else begin
      rowsFailed++;
    end
    $display("Row %0d %s addr 0x%h: %s", r, rowWrite[r] ? "write" : "read",
             rowAddr[r], (errorCount == errorsBefore) ? "ok" : "failed");
    @(negedge clk);
  endtask

  initial begin
    resetn = 1'b0;
    rd = 1'b0;
    wr = 1'b0;
    addr = '0;
    writeData = '0;
    buildTable();
    cycleLimit = rowWrite.size() * 4 + 40;
    repeat (10) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    @(negedge clk);
    for (int r = 0; r < rowWrite.size(); r++) begin
      runRow(r);
    end
    $display("Rows passed: %0d, rows failed: %0d, errors: %0d, assertion failures: %0d",
             rowsPassed, rowsFailed, errorCount,
             u_cacheTop.u_cacheTopAssertions.assertFailures);
    if (errorCount == 0 && u_cacheTop.u_cacheTopAssertions.assertFailures == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
cachePkg.sv
syncRam.sv
cacheWay.sv
ageReplacer.sv
cacheCtrl.sv
cacheTop.sv
cacheTop_assertions.sv
cacheTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = cacheTb
FILELIST = verilog.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
